// ==== common/evt_router_pkg.sv ====
package evt_router_pkg;

  // ------------------------------------------------------------------------
  // data widths
  // ------------------------------------------------------------------------
  // raw event word from the host source
  typedef logic [31:0] evt_t;

  // multicast key, also mapper masks and routing keys/masks
  typedef logic [31:0] key_t;

  // right shift of one mapper field
  typedef logic [4:0] shift_t;

  // output channel index, up to 8 channels
  typedef logic [2:0] route_t;

  // configuration register address
  typedef logic [7:0] cfg_addr_t;

  // drop wait in clock cycles, 0 waits forever
  typedef logic [15:0] wait_t;

  // status counter, wraps
  typedef logic [31:0] count_t;

  // ------------------------------------------------------------------------
  // configuration address map
  // ------------------------------------------------------------------------
  // mapper base key
  localparam cfg_addr_t ADDR_MP_KEY        = 8'h00;

  // mapper field masks and shifts, entry i at base + i
  localparam cfg_addr_t ADDR_MP_FMSK_BASE  = 8'h10;
  localparam cfg_addr_t ADDR_MP_FSFT_BASE  = 8'h18;

  // routing table, entry i at base + i
  localparam cfg_addr_t ADDR_RT_KEY_BASE   = 8'h20;
  localparam cfg_addr_t ADDR_RT_MASK_BASE  = 8'h40;
  localparam cfg_addr_t ADDR_RT_ROUTE_BASE = 8'h60;

  // dispatcher drop wait
  localparam cfg_addr_t ADDR_DROP_WAIT     = 8'h80;

endpackage

// ==== verilog/cfg_regs.sv ====
`timescale 1ns/1ps
module cfg_regs
#(
  parameter int NUM_MREGS = 4,
  parameter int NUM_RREGS = 16
)
(
  input  logic                        pl_clk0_buf_int,
  input  logic                        rst_n,

  // host write port, no read-back
  input  logic                        cfg_wr,
  input  evt_router_pkg::cfg_addr_t   cfg_addr,
  input  evt_router_pkg::key_t        cfg_wdata,

  // event mapper fields
  output evt_router_pkg::key_t        mp_key,
  output evt_router_pkg::key_t        mp_fmsk  [NUM_MREGS-1:0],
  output evt_router_pkg::shift_t      mp_fsft  [NUM_MREGS-1:0],

  // routing table
  output evt_router_pkg::key_t        rt_key   [NUM_RREGS-1:0],
  output evt_router_pkg::key_t        rt_mask  [NUM_RREGS-1:0],
  output evt_router_pkg::route_t      rt_route [NUM_RREGS-1:0],

  // dispatcher timeout
  output evt_router_pkg::wait_t       drop_wait
);

  // --------------------------------------------------------------------------
  // single registers
  // --------------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mp_key    <= '0;
      drop_wait <= '0;
    end
    else if (cfg_wr)
    begin
      if (cfg_addr == evt_router_pkg::ADDR_MP_KEY)
        mp_key <= cfg_wdata;
      // only the low bits are kept
      if (cfg_addr == evt_router_pkg::ADDR_DROP_WAIT)
        drop_wait <= evt_router_pkg::wait_t'(cfg_wdata);
    end
  end

  // --------------------------------------------------------------------------
  // mapper field banks
  // --------------------------------------------------------------------------
  // addresses past NUM_MREGS never match
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_MREGS; i++)
      begin
        mp_fmsk[i] <= '0;
        mp_fsft[i] <= '0;
      end
    end
    else if (cfg_wr)
    begin
      for (int i = 0; i < NUM_MREGS; i++)
      begin
        if (cfg_addr == evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_MP_FMSK_BASE + i))
          mp_fmsk[i] <= cfg_wdata;
        if (cfg_addr == evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_MP_FSFT_BASE + i))
          mp_fsft[i] <= evt_router_pkg::shift_t'(cfg_wdata);
      end
    end
  end

  // --------------------------------------------------------------------------
  // routing table banks
  // --------------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_RREGS; i++)
      begin
        rt_key[i]   <= '0;
        rt_mask[i]  <= '0;
        rt_route[i] <= '0;
      end
    end
    else if (cfg_wr)
    begin
      for (int i = 0; i < NUM_RREGS; i++)
      begin
        if (cfg_addr == evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_RT_KEY_BASE + i))
          rt_key[i] <= cfg_wdata;
        if (cfg_addr == evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_RT_MASK_BASE + i))
          rt_mask[i] <= cfg_wdata;
        // route index from the low bits
        if (cfg_addr == evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_RT_ROUTE_BASE + i))
          rt_route[i] <= evt_router_pkg::route_t'(cfg_wdata);
      end
    end
  end

endmodule

// ==== event_path/evt_mapper.sv ====
`timescale 1ns/1ps
module evt_mapper
#(
  parameter int NUM_MREGS = 4
)
(
  input  logic                      pl_clk0_buf_int,
  input  logic                      rst_n,

  // mapper fields from the register block
  input  evt_router_pkg::key_t      mp_key,
  input  evt_router_pkg::key_t      mp_fmsk [NUM_MREGS-1:0],
  input  evt_router_pkg::shift_t    mp_fsft [NUM_MREGS-1:0],

  // events from the host source
  input  logic                      evt_vld,
  input  evt_router_pkg::evt_t      evt_data,
  output logic                      evt_rdy,

  // mapped key to route lookup
  output logic                      map_vld,
  output evt_router_pkg::key_t      map_key,
  input  logic                      map_rdy
);

  evt_router_pkg::key_t key_nxt;

  // --------------------------------------------------------------------------
  // key build
  // --------------------------------------------------------------------------
  // base key ORed with each masked and shifted field
  always_comb
  begin
    key_nxt = mp_key;
    for (int i = 0; i < NUM_MREGS; i++)
      key_nxt = key_nxt | ((evt_data & mp_fmsk[i]) >> mp_fsft[i]);
  end

  // --------------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------------
  // free slot or slot drained this cycle
  assign evt_rdy = !map_vld || map_rdy;

  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
      map_vld <= 1'b0;
    else if (evt_vld && evt_rdy)
      map_vld <= 1'b1;
    else if (map_rdy)
      map_vld <= 1'b0;
  end

  // payload only, qualified by map_vld
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (evt_vld && evt_rdy)
      map_key <= key_nxt;
  end

endmodule

// ==== event_path/route_lookup.sv ====
`timescale 1ns/1ps
module route_lookup
#(
  parameter int NUM_RREGS    = 16,
  parameter int NUM_CHANNELS = 8
)
(
  input  logic                      pl_clk0_buf_int,
  input  logic                      rst_n,

  // routing table from the register block
  input  evt_router_pkg::key_t      rt_key   [NUM_RREGS-1:0],
  input  evt_router_pkg::key_t      rt_mask  [NUM_RREGS-1:0],
  input  evt_router_pkg::route_t    rt_route [NUM_RREGS-1:0],

  // mapped key from the mapper
  input  logic                      map_vld,
  input  evt_router_pkg::key_t      map_key,
  output logic                      map_rdy,

  // routed packet to the dispatcher
  output logic                      lkp_vld,
  output evt_router_pkg::key_t      lkp_key,
  output evt_router_pkg::route_t    lkp_route,
  input  logic                      lkp_rdy,

  // keys with no usable route
  output evt_router_pkg::count_t    unmatched_cnt
);

  logic                      hit;
  evt_router_pkg::route_t    hit_route;
  logic                      routable;
  logic                      map_acc;

  // --------------------------------------------------------------------------
  // table match
  // --------------------------------------------------------------------------
  // scan from the top so the lowest matching entry is left standing
  always_comb
  begin
    hit       = 1'b0;
    hit_route = '0;
    for (int i = NUM_RREGS - 1; i >= 0; i--)
    begin
      if ((map_key & rt_mask[i]) == rt_key[i])
      begin
        hit       = 1'b1;
        hit_route = rt_route[i];
      end
    end
  end

  // route past the last channel counts as no match
  assign routable = hit && (int'(hit_route) < NUM_CHANNELS);

  // --------------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------------
  assign map_rdy = !lkp_vld || lkp_rdy;
  assign map_acc = map_vld && map_rdy;

  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
      lkp_vld <= 1'b0;
    else if (map_acc && routable)
      lkp_vld <= 1'b1;
    else if (lkp_rdy)
      lkp_vld <= 1'b0;
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (map_acc && routable)
    begin
      lkp_key   <= map_key;
      lkp_route <= hit_route;
    end
  end

  // unroutable keys are consumed here and counted
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
      unmatched_cnt <= '0;
    else if (map_acc && !routable)
      unmatched_cnt <= unmatched_cnt + 1'b1;
  end

endmodule

// ==== event_path/chan_dispatch.sv ====
`timescale 1ns/1ps
module chan_dispatch
#(
  parameter int NUM_CHANNELS = 8
)
(
  input  logic                      pl_clk0_buf_int,
  input  logic                      rst_n,

  // drop timeout, 0 disables dropping
  input  evt_router_pkg::wait_t     drop_wait,

  // routed packet from lookup
  input  logic                      lkp_vld,
  input  evt_router_pkg::key_t      lkp_key,
  input  evt_router_pkg::route_t    lkp_route,
  output logic                      lkp_rdy,

  // output channels
  output logic [NUM_CHANNELS-1:0]   ch_vld,
  output evt_router_pkg::key_t      ch_key [NUM_CHANNELS-1:0],
  input  logic [NUM_CHANNELS-1:0]   ch_rdy,

  // packets dropped on timeout
  output evt_router_pkg::count_t    dropped_cnt
);

  // held packet
  logic                      pkt_vld;
  evt_router_pkg::key_t      pkt_key;
  evt_router_pkg::route_t    pkt_route;

  // cycles spent waiting on the channel
  evt_router_pkg::wait_t     wait_cnt;

  logic                      sent;
  logic                      drop;
  logic                      free;

  // --------------------------------------------------------------------------
  // channel outputs
  // --------------------------------------------------------------------------
  // valid only on the selected channel, key on all of them
  for (genvar c = 0; c < NUM_CHANNELS; c++)
  begin : g_chan
    assign ch_vld[c] = pkt_vld && (pkt_route == evt_router_pkg::route_t'(c));
    assign ch_key[c] = pkt_key;
  end

  // at most one channel valid, so any handshake is ours
  assign sent = |(ch_vld & ch_rdy);

  // timeout on the last allowed valid cycle
  assign drop = pkt_vld && !sent && (drop_wait != '0) &&
                (wait_cnt == drop_wait - 1'b1);

  // slot frees on delivery or on drop
  assign free    = sent || drop;
  assign lkp_rdy = !pkt_vld || free;

  // --------------------------------------------------------------------------
  // hold register and wait counter
  // --------------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pkt_vld  <= 1'b0;
      wait_cnt <= '0;
    end
    else if (lkp_vld && lkp_rdy)
    begin
      // fresh packet restarts the wait
      pkt_vld  <= 1'b1;
      wait_cnt <= '0;
    end
    else if (free)
      pkt_vld <= 1'b0;
    else if (pkt_vld)
      wait_cnt <= wait_cnt + 1'b1;
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (lkp_vld && lkp_rdy)
    begin
      pkt_key   <= lkp_key;
      pkt_route <= lkp_route;
    end
  end

  // --------------------------------------------------------------------------
  // drop counter
  // --------------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
      dropped_cnt <= '0;
    else if (drop)
      dropped_cnt <= dropped_cnt + 1'b1;
  end

endmodule

// ==== verilog/evt_router_top.sv ====
`timescale 1ns/1ps
module evt_router_top
#(
  parameter int NUM_MREGS    = 4,
  parameter int NUM_RREGS    = 16,
  parameter int NUM_CHANNELS = 8
)
(
  input  logic                        pl_clk0_buf_int,
  input  logic                        rst_n,

  // configuration writes
  input  logic                        cfg_wr,
  input  evt_router_pkg::cfg_addr_t   cfg_addr,
  input  evt_router_pkg::key_t        cfg_wdata,

  // host events
  input  logic                        evt_vld,
  input  evt_router_pkg::evt_t        evt_data,
  output logic                        evt_rdy,

  // output channels
  output logic [NUM_CHANNELS-1:0]     ch_vld,
  output evt_router_pkg::key_t        ch_key [NUM_CHANNELS-1:0],
  input  logic [NUM_CHANNELS-1:0]     ch_rdy,

  // status
  output evt_router_pkg::count_t      unmatched_cnt,
  output evt_router_pkg::count_t      dropped_cnt
);

  // --------------------------------------------------------------------------
  // internal wires
  // --------------------------------------------------------------------------
  // mapper fields
  evt_router_pkg::key_t      mp_key;
  evt_router_pkg::key_t      mp_fmsk  [NUM_MREGS-1:0];
  evt_router_pkg::shift_t    mp_fsft  [NUM_MREGS-1:0];

  // routing table
  evt_router_pkg::key_t      rt_key   [NUM_RREGS-1:0];
  evt_router_pkg::key_t      rt_mask  [NUM_RREGS-1:0];
  evt_router_pkg::route_t    rt_route [NUM_RREGS-1:0];

  evt_router_pkg::wait_t     drop_wait;

  // stage 1 to stage 2
  logic                      map_vld;
  evt_router_pkg::key_t      map_key;
  logic                      map_rdy;

  // stage 2 to stage 3
  logic                      lkp_vld;
  evt_router_pkg::key_t      lkp_key;
  evt_router_pkg::route_t    lkp_route;
  logic                      lkp_rdy;

  // --------------------------------------------------------------------------
  // configuration registers
  // --------------------------------------------------------------------------
  cfg_regs #(.NUM_MREGS (NUM_MREGS), .NUM_RREGS (NUM_RREGS)) cr (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .cfg_wr          (cfg_wr)
    , .cfg_addr        (cfg_addr)
    , .cfg_wdata       (cfg_wdata)
    , .mp_key          (mp_key)
    , .mp_fmsk         (mp_fmsk)
    , .mp_fsft         (mp_fsft)
    , .rt_key          (rt_key)
    , .rt_mask         (rt_mask)
    , .rt_route        (rt_route)
    , .drop_wait       (drop_wait)
    );

  // --------------------------------------------------------------------------
  // event path: mapper, lookup, dispatch
  // --------------------------------------------------------------------------
  evt_mapper #(.NUM_MREGS (NUM_MREGS)) em (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .mp_key          (mp_key)
    , .mp_fmsk         (mp_fmsk)
    , .mp_fsft         (mp_fsft)
    , .evt_vld         (evt_vld)
    , .evt_data        (evt_data)
    , .evt_rdy         (evt_rdy)
    , .map_vld         (map_vld)
    , .map_key         (map_key)
    , .map_rdy         (map_rdy)
    );

  route_lookup #(.NUM_RREGS (NUM_RREGS), .NUM_CHANNELS (NUM_CHANNELS)) rl (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rt_key          (rt_key)
    , .rt_mask         (rt_mask)
    , .rt_route        (rt_route)
    , .map_vld         (map_vld)
    , .map_key         (map_key)
    , .map_rdy         (map_rdy)
    , .lkp_vld         (lkp_vld)
    , .lkp_key         (lkp_key)
    , .lkp_route       (lkp_route)
    , .lkp_rdy         (lkp_rdy)
    , .unmatched_cnt   (unmatched_cnt)
    );

  chan_dispatch #(.NUM_CHANNELS (NUM_CHANNELS)) cd (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .drop_wait       (drop_wait)
    , .lkp_vld         (lkp_vld)
    , .lkp_key         (lkp_key)
    , .lkp_route       (lkp_route)
    , .lkp_rdy         (lkp_rdy)
    , .ch_vld          (ch_vld)
    , .ch_key          (ch_key)
    , .ch_rdy          (ch_rdy)
    , .dropped_cnt     (dropped_cnt)
    );

endmodule

// ==== bench/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// --------------------------------------------------------------------------
// register mirror
// --------------------------------------------------------------------------
// every register resets to zero, so the mirror starts there too
evt_router_pkg::key_t   m_mp_key = '0;
evt_router_pkg::key_t   m_fmsk     [NUM_MREGS] = '{default: '0};
evt_router_pkg::shift_t m_fsft     [NUM_MREGS] = '{default: '0};

// routing table copy
evt_router_pkg::key_t   m_rt_key   [NUM_RREGS] = '{default: '0};
evt_router_pkg::key_t   m_rt_mask  [NUM_RREGS] = '{default: '0};
evt_router_pkg::route_t m_rt_route [NUM_RREGS] = '{default: '0};

// --------------------------------------------------------------------------
// reference model
// --------------------------------------------------------------------------
// base key plus each field, masked then shifted right
function automatic evt_router_pkg::key_t key_from_event(input evt_router_pkg::evt_t ev);
  evt_router_pkg::key_t k;
  k = m_mp_key;
  for (int i = 0; i < NUM_MREGS; i++)
  begin
    k = k | ((ev & m_fmsk[i]) >> m_fsft[i]);
  end
  return k;
endfunction

// first matching entry wins, -1 when the key cannot be routed
function automatic int route_for_key(input evt_router_pkg::key_t k);
  int r;
  r = -2;
  for (int i = 0; i < NUM_RREGS && r == -2; i++)
  begin
    if ((k & m_rt_mask[i]) == m_rt_key[i])
      r = int'(m_rt_route[i]);
  end
  // no hit at all, or a route past the last channel
  if (r < 0 || r >= NUM_CHANNELS)
    return -1;
  return r;
endfunction

`endif

// ==== bench/tb_evt_router.sv ====
`timescale 1ns/1ps
module tb_evt_router;

  localparam int NUM_MREGS    = 4;
  localparam int NUM_RREGS    = 16;
  // six channels, so routes 6 and 7 point past the last channel
  localparam int NUM_CHANNELS = 6;
  localparam int WAIT_LIMIT   = 500;
  localparam logic [31:0] SEED = 32'h7c3e_8e00;

  logic                         pl_clk0_buf_int = 1'b0;
  logic                         rst_n;
  logic                         cfg_wr;
  evt_router_pkg::cfg_addr_t    cfg_addr;
  evt_router_pkg::key_t         cfg_wdata;
  logic                         evt_vld;
  evt_router_pkg::evt_t         evt_data;
  logic                         evt_rdy;
  logic [NUM_CHANNELS-1:0]      ch_vld;
  evt_router_pkg::key_t         ch_key [NUM_CHANNELS-1:0];
  wire  [NUM_CHANNELS-1:0]      ch_rdy;
  evt_router_pkg::count_t       unmatched_cnt;
  evt_router_pkg::count_t       dropped_cnt;

  // expected keys per channel, in sending order
  evt_router_pkg::key_t         exp_q [NUM_CHANNELS][$];
  evt_router_pkg::count_t       exp_unmatched = '0;
  evt_router_pkg::count_t       exp_dropped   = '0;

  // sink controls
  logic [NUM_CHANNELS-1:0]      hold_mask = '0;
  logic                         stall_on  = 1'b0;

  `include "tb_ref.svh"

  always #2 pl_clk0_buf_int = ~pl_clk0_buf_int;

  evt_router_top #(
    .NUM_MREGS    (NUM_MREGS),
    .NUM_RREGS    (NUM_RREGS),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) UUT (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .cfg_wr          (cfg_wr),
    .cfg_addr        (cfg_addr),
    .cfg_wdata       (cfg_wdata),
    .evt_vld         (evt_vld),
    .evt_data        (evt_data),
    .evt_rdy         (evt_rdy),
    .ch_vld          (ch_vld),
    .ch_key          (ch_key),
    .ch_rdy          (ch_rdy),
    .unmatched_cnt   (unmatched_cnt),
    .dropped_cnt     (dropped_cnt)
  );

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  task automatic stop_run(input string what);
    $display("TESTS FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic check_key(input string name, input evt_router_pkg::key_t got,
                           input evt_router_pkg::key_t exp);
    if (got !== exp)
    begin
      $display("TESTS FAILED");
      $fatal(1, "error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input evt_router_pkg::count_t got,
                             input evt_router_pkg::count_t exp);
    if (got !== exp)
    begin
      $display("TESTS FAILED");
      $fatal(1, "error %s got %h expected %h", name, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // channel sinks
  // --------------------------------------------------------------------------
  for (genvar c = 0; c < NUM_CHANNELS; c++)
  begin : g_sink
    logic rdy     = 1'b1;
    int   low_run = 0;

    assign ch_rdy[c] = rdy;

    // ready pattern, at most 3 low cycles in a row when stalling
    always @(posedge pl_clk0_buf_int)
    begin
      if (hold_mask[c])
        rdy <= 1'b0;
      else if (stall_on && low_run < 3 && ($urandom() % 4) == 0)
      begin
        rdy     <= 1'b0;
        low_run <= low_run + 1;
      end
      else
      begin
        rdy     <= 1'b1;
        low_run <= 0;
      end
    end

    // a transfer completes on the next rising edge
    always @(negedge pl_clk0_buf_int)
    begin
      if (rst_n === 1'b1 && ch_vld[c] && ch_rdy[c])
      begin
        if (exp_q[c].size() == 0)
          stop_run($sformatf("key %h delivered on channel %0d with none expected",
                             ch_key[c], c));
        else
          check_key($sformatf("ch_key[%0d]", c), ch_key[c], exp_q[c].pop_front());
      end
    end
  end

  // only one channel may be valid
  always @(negedge pl_clk0_buf_int)
  begin
    if (rst_n === 1'b1 && $countones(ch_vld) > 1)
      stop_run("more than one channel is valid at once");
  end

  // --------------------------------------------------------------------------
  // configuration writes, mirrored for the reference model
  // --------------------------------------------------------------------------
  task automatic write_cfg(input evt_router_pkg::cfg_addr_t addr,
                           input evt_router_pkg::key_t data);
    @(posedge pl_clk0_buf_int);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge pl_clk0_buf_int);
    cfg_wr    <= 1'b0;
  endtask

  task automatic load_base_key(input evt_router_pkg::key_t k);
    write_cfg(evt_router_pkg::ADDR_MP_KEY, k);
    m_mp_key = k;
  endtask

  task automatic load_field(input int i, input evt_router_pkg::key_t msk,
                            input evt_router_pkg::shift_t sft);
    write_cfg(evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_MP_FMSK_BASE + i), msk);
    write_cfg(evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_MP_FSFT_BASE + i),
              evt_router_pkg::key_t'(sft));
    m_fmsk[i] = msk;
    m_fsft[i] = sft;
  endtask

  task automatic route_entry(input int i, input evt_router_pkg::key_t k,
                             input evt_router_pkg::key_t msk,
                             input evt_router_pkg::route_t r);
    write_cfg(evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_RT_KEY_BASE + i), k);
    write_cfg(evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_RT_MASK_BASE + i), msk);
    write_cfg(evt_router_pkg::cfg_addr_t'(evt_router_pkg::ADDR_RT_ROUTE_BASE + i),
              evt_router_pkg::key_t'(r));
    m_rt_key[i]   = k;
    m_rt_mask[i]  = msk;
    m_rt_route[i] = r;
  endtask

  task automatic set_drop_wait(input evt_router_pkg::wait_t w);
    write_cfg(evt_router_pkg::ADDR_DROP_WAIT, evt_router_pkg::key_t'(w));
  endtask

  // zero mask with a nonzero key never matches
  task automatic clear_table();
    for (int i = 0; i < NUM_RREGS; i++)
      route_entry(i, 32'hffff_ffff, 32'h0, 3'd0);
  endtask

  // four fields, channel taken from the low 3 key bits
  task automatic mapped_setup();
    load_base_key(32'h8000_0000);
    load_field(0, 32'h0000_000f, 5'd0);
    load_field(1, 32'h0000_0f00, 5'd4);
    load_field(2, 32'h00ff_0000, 5'd8);
    load_field(3, 32'hf000_0000, 5'd12);
    clear_table();
    for (int c = 0; c < 8; c++)
      route_entry(c, evt_router_pkg::key_t'(c), 32'h7,
                  evt_router_pkg::route_t'(c % NUM_CHANNELS));
  endtask

  // --------------------------------------------------------------------------
  // event source
  // --------------------------------------------------------------------------
  // expected outcome is booked before the event goes out
  task automatic send_event(input evt_router_pkg::evt_t ev);
    evt_router_pkg::key_t k;
    int r;
    int n;
    k = key_from_event(ev);
    r = route_for_key(k);
    if (r < 0)
      exp_unmatched = exp_unmatched + 1;
    else if (hold_mask[r])
      exp_dropped = exp_dropped + 1;
    else
      exp_q[r].push_back(k);
    @(posedge pl_clk0_buf_int);
    evt_vld  <= 1'b1;
    evt_data <= ev;
    n = 0;
    @(negedge pl_clk0_buf_int);
    while (!evt_rdy)
    begin
      if (n == WAIT_LIMIT)
        stop_run("event source timed out waiting for evt_rdy");
      n++;
      @(negedge pl_clk0_buf_int);
    end
  endtask

  // the last event transfers on this edge
  task automatic finish_burst();
    @(posedge pl_clk0_buf_int);
    evt_vld <= 1'b0;
  endtask

  function automatic bit pipeline_settled();
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      if (exp_q[c].size() != 0)
        return 1'b0;
    end
    return (unmatched_cnt == exp_unmatched) && (dropped_cnt == exp_dropped);
  endfunction

  task automatic wait_drained();
    int n;
    n = 0;
    @(negedge pl_clk0_buf_int);
    while (!pipeline_settled() && n < WAIT_LIMIT)
    begin
      n++;
      @(negedge pl_clk0_buf_int);
    end
    check_count("unmatched_cnt", unmatched_cnt, exp_unmatched);
    check_count("dropped_cnt", dropped_cnt, exp_dropped);
    if (!pipeline_settled())
      stop_run("timed out waiting for expected packets on the channels");
  endtask

  // --------------------------------------------------------------------------
  // scenarios
  // --------------------------------------------------------------------------
  initial
  begin
    void'($urandom(SEED));
    rst_n     <= 1'b0;
    cfg_wr    <= 1'b0;
    cfg_addr  <= '0;
    cfg_wdata <= '0;
    evt_vld   <= 1'b0;
    evt_data  <= '0;
    repeat (4) @(posedge pl_clk0_buf_int);
    rst_n <= 1'b1;

    // idle state right after reset
    @(negedge pl_clk0_buf_int);
    if (ch_vld !== '0)
      stop_run("a channel is valid right after reset");
    if (evt_rdy !== 1'b1)
      stop_run("evt_rdy is not high right after reset");
    check_count("unmatched_cnt", unmatched_cnt, '0);
    check_count("dropped_cnt", dropped_cnt, '0);

    // random events through the four-field mapping
    mapped_setup();
    for (int i = 0; i < 40; i++)
      send_event($urandom());
    finish_burst();
    wait_drained();

    // random sink stalls, shorter than the drop wait
    set_drop_wait(16'd16);
    stall_on = 1'b1;
    for (int i = 0; i < 60; i++)
      send_event($urandom());
    finish_burst();
    wait_drained();
    stall_on = 1'b0;

    // channel 3 stuck, every packet to it times out
    set_drop_wait(16'd8);
    hold_mask[3] = 1'b1;
    for (int i = 0; i < 4; i++)
      send_event(($urandom() & ~32'h7) | 32'h3);
    finish_burst();
    wait_drained();
    hold_mask[3] = 1'b0;
    for (int i = 0; i < 12; i++)
      send_event(($urandom() & ~32'h7) | evt_router_pkg::evt_t'(i % 3));
    finish_burst();
    wait_drained();

    // key equals event; entry 0 overlaps the catch-all entry 1
    load_base_key(32'h0);
    load_field(0, 32'hffff_ffff, 5'd0);
    for (int i = 1; i < NUM_MREGS; i++)
      load_field(i, 32'h0, 5'd0);
    clear_table();
    route_entry(0, 32'h0000_0100, 32'h0000_0f00, 3'd5);
    route_entry(1, 32'h0, 32'h0, 3'd2);
    send_event(32'h0000_0100);
    send_event(32'h0000_0201);
    send_event(32'habcd_0100);
    send_event(32'h0000_0000);
    send_event(32'h0000_0f00);
    send_event(32'h1111_0100);
    finish_burst();
    wait_drained();

    // low bits 10 miss, low bits 01 route past the last channel
    route_entry(0, 32'h0, 32'h3, 3'd1);
    route_entry(1, 32'h1, 32'h3, 3'd7);
    for (int i = 0; i < 40; i++)
      send_event($urandom());
    finish_burst();
    wait_drained();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+bench
common/evt_router_pkg.sv
verilog/cfg_regs.sv
event_path/evt_mapper.sv
event_path/route_lookup.sv
event_path/chan_dispatch.sv
verilog/evt_router_top.sv
bench/tb_evt_router.sv

// ==== Makefile ====
# Verilator build and run of the event router testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and search sim.log for failures"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_evt_router
	./obj_dir/Vtb_evt_router > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
